// File: verilog/ifu_defs.svh
/*
 instruction fetch front end shared macros
 widths, reset vector, nop word and the opcodes predecode looks at
 */
`ifndef IFU_DEFS_SVH
`define IFU_DEFS_SVH

// bus and datapath widths
`define IFU_ADDR_W    32
`define IFU_DATA_W    32
`define IFU_SEL_W     4             // one select bit per byte lane

// first fetch address after reset
`define IFU_RESET_PC  32'h0000_0000

// addi x0, x0, 0
`define IFU_INST_NOP  32'h0000_0013

// major opcodes that carry an immediate in the i or s view
`define IFU_OPC_LOAD    7'b0000011
`define IFU_OPC_OP_IMM  7'b0010011
`define IFU_OPC_JALR    7'b1100111
`define IFU_OPC_STORE   7'b0100011

`endif

// File: verilog/ifu_pkg.sv
/*
 fetch front end types
 hold levels, instruction format views and the structs passed between stages
 */
`include "ifu_defs.svh"

package ifu_pkg;

    // ordered so a stage is held when level >= its own
    typedef enum logic [1:0] {
        HOLD_NONE = 2'd0,
        HOLD_PC   = 2'd1,
        HOLD_IF   = 2'd2,
        HOLD_ID   = 2'd3
    } hold_level_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } inst_i_t;

    typedef struct packed {
        logic [6:0] imm_hi;         // imm[11:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;         // imm[4:0]
        logic [6:0] opcode;
    } inst_s_t;

    // same 32 bit word, three decodings
    typedef union packed {
        inst_r_t r;
        inst_i_t i;
        inst_s_t s;
    } inst_u;

    typedef struct packed {
        logic                   valid;
        logic [`IFU_ADDR_W-1:0] addr;
        inst_u                  inst;
    } fetch_t;                      // 65 bits

    typedef struct packed {
        logic                   en;
        logic [`IFU_ADDR_W-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [`IFU_ADDR_W-1:0] adr;
        logic [`IFU_SEL_W-1:0]  sel;
    } wb_req_t;

    typedef struct packed {
        logic                   valid;
        logic [`IFU_ADDR_W-1:0] pc;
        logic [6:0]             opcode;
        logic [4:0]             rd;
        logic [4:0]             rs1;
        logic [4:0]             rs2;
        logic [2:0]             funct3;
        logic [6:0]             funct7;
        logic [31:0]            imm;    // sign extended
    } predec_t;

endpackage

// File: verilog/ifu_pipe_ctrl.sv
/*
 pipeline control
 folds redirect and stall requests into a single hold level
 */
module ifu_pipe_ctrl (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  ifu_pkg::redirect_t      redirect_i,     // from execute
    input  logic                    stall_i,        // from later stages
    output ifu_pkg::hold_level_e    hold_level_o
);

    // redirect wins over stall
    always_comb begin
        if (redirect_i.en) begin
            hold_level_o = ifu_pkg::HOLD_ID;     // flush fetch and predecode
        end else if (stall_i) begin
            hold_level_o = ifu_pkg::HOLD_IF;     // freeze pc and fetch address
        end else begin
            hold_level_o = ifu_pkg::HOLD_NONE;
        end
    end

    // HOLD_PC is never raised here
    // an X on either request would otherwise slip through as a silent level
    a_level_legal: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        !$isunknown(hold_level_o) &&
        (hold_level_o inside {ifu_pkg::HOLD_NONE, ifu_pkg::HOLD_IF, ifu_pkg::HOLD_ID})
    ) else $error("hold level left the legal set: %0d", hold_level_o);

endmodule

// File: verilog/ifu_pc_reg.sv
/*
 program counter
 reset vector, redirect load and +4 advance when a fetch response is consumed
 */
`include "ifu_defs.svh"

module ifu_pc_reg (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  ifu_pkg::hold_level_e    hold_level_i,
    input  ifu_pkg::redirect_t      redirect_i,
    input  logic                    consume_i,      // response taken by fetch stage
    output logic [`IFU_ADDR_W-1:0]  pc_o
);

    logic [`IFU_ADDR_W-1:0] pc_q;
    logic                   pc_hold;

    // same compare as every other stage
    assign pc_hold = (hold_level_i >= ifu_pkg::HOLD_PC);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q <= `IFU_RESET_PC;
        end else if (redirect_i.en) begin
            pc_q <= redirect_i.target;      // jump target, next cycle
        end else if (consume_i && !pc_hold) begin
            pc_q <= pc_q + `IFU_ADDR_W'd4;  // sequential
        end
    end

    assign pc_o = pc_q;

    // targets come from outside the front end
    // no compressed support so every fetch address must be word aligned
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        pc_q[1:0] == 2'b00
    ) else $error("pc not word aligned: %h", pc_q);

endmodule

// File: verilog/ifu_wb_master.sv
/*
 wishbone classic instruction read master
 one read at a time, response held in rsp until the fetch stage takes it
 */
`include "ifu_defs.svh"

module ifu_wb_master (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic [`IFU_ADDR_W-1:0]  pc_i,
    input  ifu_pkg::redirect_t      redirect_i,
    input  logic                    consume_i,
    output ifu_pkg::wb_req_t        wb_req_o,
    input  logic [`IFU_DATA_W-1:0]  wb_dat_i,
    input  logic                    wb_ack_i,
    output ifu_pkg::fetch_t         rsp_o
);

    logic                   cyc_q;      // cyc and stb move together
    logic                   stale_q;    // pending cycle belongs to the old path
    logic [`IFU_ADDR_W-1:0] adr_q;
    logic                   ack_fire;
    logic                   ack_take;
    logic                   start;
    logic [`IFU_ADDR_W-1:0] next_adr;

    logic                   rsp_valid_q;
    logic [`IFU_ADDR_W-1:0] rsp_addr_q;
    ifu_pkg::inst_u         rsp_inst_q;

    assign ack_fire = cyc_q && wb_ack_i;
    assign ack_take = ack_fire && !stale_q && !redirect_i.en;  // drop old-path data

    // new cycle only from idle, and only if rsp frees up
    assign start = !cyc_q && (redirect_i.en || !rsp_valid_q || consume_i);

    // pc points at rsp while it is full, so step past it on consume
    always_comb begin
        if (redirect_i.en) begin
            next_adr = redirect_i.target;
        end else if (consume_i) begin
            next_adr = pc_i + `IFU_ADDR_W'd4;
        end else begin
            next_adr = pc_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            cyc_q   <= 1'b0;
            stale_q <= 1'b0;
        end else if (ack_fire) begin
            cyc_q   <= 1'b0;            // drop the cycle after ack
            stale_q <= 1'b0;
        end else if (start) begin
            cyc_q   <= 1'b1;
        end else if (cyc_q && redirect_i.en) begin
            stale_q <= 1'b1;            // must still finish the cycle
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            adr_q <= next_adr;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rsp_valid_q <= 1'b0;
        end else if (redirect_i.en) begin
            rsp_valid_q <= 1'b0;        // flushed
        end else if (ack_take) begin
            rsp_valid_q <= 1'b1;
        end else if (consume_i) begin
            rsp_valid_q <= 1'b0;
        end
    end

    // payload, no reset
    always_ff @(posedge clk) begin
        if (ack_take) begin
            rsp_addr_q <= adr_q;
            rsp_inst_q <= wb_dat_i;
        end
    end

    assign wb_req_o = '{cyc: cyc_q, stb: cyc_q, we: 1'b0, adr: adr_q, sel: '1};
    assign rsp_o    = '{valid: rsp_valid_q, addr: rsp_addr_q, inst: rsp_inst_q};

    a_stb_cyc: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        wb_req_o.stb |-> wb_req_o.cyc
    ) else $error("wishbone stb without cyc");

    // the slave may stretch the cycle for any number of waits
    a_adr_hold: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        wb_req_o.stb && !wb_ack_i |=> wb_req_o.stb && $stable(wb_req_o.adr)
    ) else $error("wishbone request changed before ack");

endmodule

// File: verilog/ifu_ifetch.sv
/*
 fetch stage register
 passes instruction and address to predecode, freezes under hold, emits nop bubbles
 */
`include "ifu_defs.svh"

module ifu_ifetch (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  ifu_pkg::hold_level_e    hold_level_i,
    input  ifu_pkg::fetch_t         rsp_i,          // from the bus master
    output ifu_pkg::fetch_t         fetch_o
);

    logic                   hold_en;
    logic                   hold_q;     // last edge did not load
    logic                   valid_q;
    logic [`IFU_ADDR_W-1:0] addr_q;
    ifu_pkg::inst_u         inst_q;

    assign hold_en = (hold_level_i >= ifu_pkg::HOLD_IF);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            hold_q  <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            hold_q <= hold_en;
            if (!hold_en) begin
                valid_q <= rsp_i.valid;
            end
        end
    end

    // address and word stay together so they line up behind the bus response
    always_ff @(posedge clk) begin
        if (!hold_en) begin
            addr_q <= rsp_i.addr;
            inst_q <= rsp_i.inst;
        end
    end

    // frozen contents are shown once only, then masked
    always_comb begin
        fetch_o.addr  = addr_q;
        fetch_o.valid = valid_q && !hold_q;
        if (hold_q) begin
            fetch_o.inst = `IFU_INST_NOP;      // bubble
        end else begin
            fetch_o.inst = inst_q;
        end
    end

endmodule

// File: verilog/ifu_predecode.sv
/*
 predecode stage
 splits the instruction word into register, function and immediate fields
 */
`include "ifu_defs.svh"

module ifu_predecode (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  ifu_pkg::hold_level_e    hold_level_i,
    input  ifu_pkg::fetch_t         fetch_i,
    output ifu_pkg::predec_t        predec_o
);

    ifu_pkg::inst_u     word;
    ifu_pkg::predec_t   dec;
    ifu_pkg::predec_t   pd_q;       // payload only
    logic               valid_q;
    logic               flush;

    assign word  = fetch_i.inst;
    assign flush = (hold_level_i == ifu_pkg::HOLD_ID);

    always_comb begin
        dec.valid  = fetch_i.valid;
        dec.pc     = fetch_i.addr;
        dec.opcode = word.r.opcode;     // fixed positions in every format
        dec.rd     = word.r.rd;
        dec.rs1    = word.r.rs1;
        dec.rs2    = word.r.rs2;
        dec.funct3 = word.r.funct3;
        dec.funct7 = word.r.funct7;
        case (word.r.opcode)
            `IFU_OPC_OP_IMM, `IFU_OPC_LOAD, `IFU_OPC_JALR: begin
                dec.imm = {{20{word.i.imm12[11]}}, word.i.imm12};
            end
            `IFU_OPC_STORE: begin
                dec.imm = {{20{word.s.imm_hi[6]}}, word.s.imm_hi, word.s.imm_lo};
            end
            default: begin
                dec.imm = '0;           // no immediate handled here
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= fetch_i.valid && !flush;
        end
    end

    always_ff @(posedge clk) begin
        pd_q <= dec;
    end

    always_comb begin
        predec_o       = pd_q;
        predec_o.valid = valid_q;
    end

    // second cycle relies on the fetch stage bubble behind the flush
    a_flush_quiet: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        flush |=> !predec_o.valid [*2]
    ) else $error("valid predecode output right after a flush");

endmodule

// File: verilog/ifu_top.sv
/*
 instruction fetch front end
 pipeline control, pc, wishbone master, fetch stage and predecode
 */
`include "ifu_defs.svh"

module ifu_top (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  ifu_pkg::redirect_t      redirect_i,
    input  logic                    stall_i,
    output ifu_pkg::wb_req_t        wb_req_o,
    input  logic [`IFU_DATA_W-1:0]  wb_dat_i,
    input  logic                    wb_ack_i,
    output ifu_pkg::predec_t        predec_o
);

    ifu_pkg::hold_level_e   hold_level;
    ifu_pkg::fetch_t        rsp;
    ifu_pkg::fetch_t        fetch;
    logic [`IFU_ADDR_W-1:0] pc;

    // response taken whenever the fetch stage is not held
    wire consume = rsp.valid && (hold_level < ifu_pkg::HOLD_IF);

    ifu_pipe_ctrl u_pipe_ctrl (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .redirect_i   (redirect_i),
        .stall_i      (stall_i),
        .hold_level_o (hold_level)
    );

    ifu_pc_reg u_pc_reg (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .hold_level_i (hold_level),
        .redirect_i   (redirect_i),
        .consume_i    (consume),
        .pc_o         (pc)
    );

    ifu_wb_master u_wb_master (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .pc_i         (pc),
        .redirect_i   (redirect_i),
        .consume_i    (consume),
        .wb_req_o     (wb_req_o),
        .wb_dat_i     (wb_dat_i),
        .wb_ack_i     (wb_ack_i),
        .rsp_o        (rsp)
    );

    ifu_ifetch u_ifetch (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .hold_level_i (hold_level),
        .rsp_i        (rsp),
        .fetch_o      (fetch)
    );

    ifu_predecode u_predecode (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .hold_level_i (hold_level),
        .fetch_i      (fetch),
        .predec_o     (predec_o)
    );

endmodule

// File: tests/ifu_tb_mem.sv
/*
 wishbone classic memory model for the fetch testbench
 known program image, 0 to 3 random wait states, slave side request monitor
 */
module ifu_tb_mem (
    input  logic             clk,
    input  logic             rst_n_i,
    input  ifu_pkg::wb_req_t wb_req_i,
    output logic [31:0]      wb_dat_o,
    output logic             wb_ack_o,
    output int               bus_errors_o   // monitor hits
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int WORDS = 1024;    // 4 KB image

    logic [31:0] prog [WORDS];
    logic [1:0]  wait_q;            // wait states still to go
    logic        busy_q;            // wait count drawn for this cycle

    // mix of r, i and s format words, every index bit reaches the upper bits
    function automatic logic [31:0] image_word(input int unsigned idx);
        logic [31:0] h;
        logic [6:0]  opc;
        h = (idx * 32'h9e37_79b1) ^ (idx << 17) ^ 32'h5a5a_0f0f;
        case (idx % 8)
            0, 4:    opc = 7'b0110011;  // OP, r format
            1, 5:    opc = 7'b0010011;  // OP-IMM
            2, 6:    opc = 7'b0100011;  // STORE
            3:       opc = 7'b0000011;  // LOAD
            default: opc = idx[3] ? 7'b1100111 : 7'b0110111;   // JALR or LUI
        endcase
        return {h[31:7], opc};
    endfunction

    initial begin
        for (int a = 0; a < WORDS; a++) begin
            prog[a[9:0]] = image_word(a);
        end
        wb_ack_o     = 1'b0;
        wb_dat_o     = '0;
        wait_q       = '0;
        busy_q       = 1'b0;
        bus_errors_o = 0;
    end

    // registered ack, one beat per request
    always @(posedge clk) begin
        logic [1:0] w;
        if (!rst_n_i) begin
            wb_ack_o <= 1'b0;
            busy_q   <= 1'b0;
        end else if (wb_ack_o) begin
            wb_ack_o <= 1'b0;               // master drops cyc at this edge
        end else if (wb_req_i.cyc && wb_req_i.stb) begin
            w = busy_q ? wait_q : 2'($urandom_range(3, 0));
            if (w == 2'd0) begin
                wb_ack_o <= 1'b1;
                wb_dat_o <= prog[wb_req_i.adr[11:2]];
                busy_q   <= 1'b0;
            end else begin
                wait_q <= w - 2'd1;
                busy_q <= 1'b1;
            end
        end
    end

    // request must sit still until ack
    adr_stable: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        wb_req_i.stb && !wb_ack_o |=> wb_req_i.stb && $stable(wb_req_i.adr)
    ) else begin
        bus_errors_o++;
        $display("bus error at %0t ns: address or strobe changed while waiting for ack", $time);
    end

    read_only: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        wb_req_i.stb |-> wb_req_i.cyc && !wb_req_i.we && wb_req_i.sel == 4'hf
    ) else begin
        bus_errors_o++;
        $display("bus error at %0t ns: strobe without cyc, a write or a partial select", $time);
    end

    // classic cycle ends right after ack, no bursts
    cyc_drop: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        wb_ack_o |=> !wb_req_i.cyc
    ) else begin
        bus_errors_o++;
        $display("bus error at %0t ns: cyc still high the cycle after ack", $time);
    end

endmodule

// File: tests/ifu_tb.sv
/*
 testbench for the instruction fetch front end
 random stalls, redirects and bus wait states checked against a predecode reference
 */
`include "ifu_defs.svh"

module ifu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ITEMS      = 400;    // predecoded words to see in total
    localparam int IDLE_LIMIT = 200;    // cycles without a new word before giving up

    logic                   clk;
    logic                   rst_n;
    ifu_pkg::redirect_t     redirect;
    logic                   stall;
    ifu_pkg::wb_req_t       wb_req;
    logic [`IFU_DATA_W-1:0] wb_dat;
    logic                   wb_ack;
    ifu_pkg::predec_t       predec;

    int          errors;            // field mismatches
    int          other_errors;      // timeouts, coverage holes
    int          bus_errors;        // from the memory monitor
    int          checked;
    int          pend_redirects;    // redirects that hit an open bus cycle
    logic [31:0] exp_pc;            // next address the stream must show

    ifu_top DUT (
        .clk        (clk),
        .rst_n_i    (rst_n),
        .redirect_i (redirect),
        .stall_i    (stall),
        .wb_req_o   (wb_req),
        .wb_dat_i   (wb_dat),
        .wb_ack_i   (wb_ack),
        .predec_o   (predec)
    );

    ifu_tb_mem u_mem (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .wb_req_i     (wb_req),
        .wb_dat_o     (wb_dat),
        .wb_ack_o     (wb_ack),
        .bus_errors_o (bus_errors)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;     // 20 ns period
    end

    // RV32I field positions, imm from the I or S layout by major opcode
    function automatic ifu_pkg::predec_t expect_fields(input logic [31:0] addr);
        logic [31:0]      w;
        ifu_pkg::predec_t p;
        w        = u_mem.prog[addr[11:2]];
        p.valid  = 1'b1;
        p.pc     = addr;
        p.opcode = w[6:0];
        p.rd     = w[11:7];
        p.funct3 = w[14:12];
        p.rs1    = w[19:15];
        p.rs2    = w[24:20];
        p.funct7 = w[31:25];
        case (w[6:0])
            7'b0010011, 7'b0000011, 7'b1100111: p.imm = {{20{w[31]}}, w[31:20]};
            7'b0100011: p.imm = {{20{w[31]}}, w[31:25], w[11:7]};   // store split imm
            default:    p.imm = 32'h0;
        endcase
        return p;
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got === want) else begin
            errors++;
            $display("Mismatch at %0t ns: predec_o.%s is %h, expected %h",
                     $time, name, got, want);
        end
    endtask

    // outputs settle long before the falling edge
    initial begin : compare
        ifu_pkg::predec_t want;
        exp_pc  = `IFU_RESET_PC;
        checked = 0;
        errors  = 0;
        forever begin
            @(negedge clk);
            if (rst_n && predec.valid) begin
                want = expect_fields(exp_pc);
                check_field("pc", predec.pc, want.pc);
                check_field("opcode", 32'(predec.opcode), 32'(want.opcode));
                check_field("rd", 32'(predec.rd), 32'(want.rd));
                check_field("rs1", 32'(predec.rs1), 32'(want.rs1));
                check_field("rs2", 32'(predec.rs2), 32'(want.rs2));
                check_field("funct3", 32'(predec.funct3), 32'(want.funct3));
                check_field("funct7", 32'(predec.funct7), 32'(want.funct7));
                check_field("imm", predec.imm, want.imm);
                exp_pc = exp_pc + 4;
                checked++;
            end
            if (rst_n && redirect.en) begin
                exp_pc = redirect.target;   // younger words are flushed
            end
        end
    end

    // random traffic until the stream reaches target_items
    task automatic run_phase(input int target_items, input int stall_odds,
                             input int redir_odds);
        int idle;
        int last;
        idle = 0;
        last = checked;
        while (checked < target_items && idle < IDLE_LIMIT) begin
            @(posedge clk);
            #2;
            stall = (stall_odds != 0) && ($urandom_range(stall_odds - 1, 0) == 0);
            if (redirect.en || redir_odds == 0) begin
                redirect.en = 1'b0;         // single cycle pulses
            end else begin
                redirect.en = ($urandom_range(redir_odds - 1, 0) == 0);
                if (redirect.en) begin
                    redirect.target = $urandom_range(255, 0) * 4;   // low 1 KB
                    if (wb_req.cyc) begin
                        pend_redirects++;
                    end
                end
            end
            if (checked != last) begin
                idle = 0;
                last = checked;
            end else begin
                idle++;
            end
        end
        if (idle >= IDLE_LIMIT) begin
            other_errors++;
            $display("timeout at %0t ns: no predecoded word for %0d cycles",
                     $time, IDLE_LIMIT);
        end
    endtask

    task automatic end_of_run();
        $display("checked %0d words, errors: %0d mismatch, %0d bus, %0d other",
                 checked, errors, bus_errors, other_errors);
        if (errors + bus_errors + other_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    initial begin : stimulus
        void'($urandom(32'hcb5c_9a02));
        $timeformat(-9, 0, "", 0);          // report times in ns
        rst_n          = 1'b0;
        stall          = 1'b0;
        redirect       = '0;
        other_errors   = 0;
        pend_redirects = 0;
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        run_phase(32, 0, 0);                // plain stream from the reset vector
        if (other_errors == 0) begin
            run_phase(150, 6, 0);           // stall pulses only
        end
        if (other_errors == 0) begin
            run_phase(ITEMS, 6, 16);        // stalls and redirects
        end
        assert (pend_redirects > 0) else begin
            other_errors++;
            $display("no redirect arrived while a bus cycle was pending");
        end
        end_of_run();
    end

endmodule

// File: build.f
+incdir+verilog
verilog/ifu_pkg.sv
verilog/ifu_pipe_ctrl.sv
verilog/ifu_pc_reg.sv
verilog/ifu_wb_master.sv
verilog/ifu_ifetch.sv
verilog/ifu_predecode.sv
verilog/ifu_top.sv
tests/ifu_tb_mem.sv
tests/ifu_tb.sv

// File: run.sh
#!/bin/sh
# build and run the fetch front end testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module ifu_tb -f build.f

./obj_dir/Vifu_tb > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q '^TEST RESULT: PASS$' sim.log; then
    echo "run.sh: simulation passed"
else
    echo "run.sh: simulation failed" >&2
    exit 1
fi
